/* verilog/axi_bridge_pkg.sv */
package axi_bridge_pkg;

	// bus geometry
	localparam int addr_w     = 32;
	localparam int data_w     = 32;
	localparam int line_words = 4;
	localparam int id_w       = 4;

	// byte offset bits inside one cache line
	localparam int line_off_w = $clog2(line_words * data_w / 8);

	localparam logic [7:0] line_len = 8'(line_words - 1); // arlen/awlen of a line burst

	// cache request type, only req_line makes a burst
	typedef enum logic [2:0] {
		req_byte = 3'b000,
		req_half = 3'b001,
		req_word = 3'b010,
		req_line = 3'b100
	} req_type_e;

	// read owner tags carried on arid/rid
	localparam logic [id_w-1:0] id_icache = 4'd0;
	localparam logic [id_w-1:0] id_dcache = 4'd1;

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,  // arvalid up
		rd_data,  // rready up
		rd_done   // last beat on the return port
	} rd_state_e;

	typedef enum logic [2:0] {
		wr_idle,
		wr_both,       // aw and w both outstanding
		wr_addr_only,  // w finished, aw still out
		wr_data_only,  // aw finished, w still out
		wr_resp        // waiting on b
	} wr_state_e;

endpackage

/* verilog/axi_read_engine.sv */
`timescale 1ns/1ps

module axi_read_engine (
	input  logic                                aclk,
	input  logic                                aresetn,
	// icache read port
	input  logic                                icache_rd_req,
	input  logic [2:0]                          icache_rd_type,
	input  logic [axi_bridge_pkg::addr_w-1:0]   icache_rd_addr,
	output logic                                icache_rd_rdy,
	output logic                                icache_ret_valid,
	output logic                                icache_ret_last,
	output logic [axi_bridge_pkg::data_w-1:0]   icache_ret_data,
	// dcache read port
	input  logic                                dcache_rd_req,
	input  logic [2:0]                          dcache_rd_type,
	input  logic [axi_bridge_pkg::addr_w-1:0]   dcache_rd_addr,
	output logic                                dcache_rd_rdy,
	output logic                                dcache_ret_valid,
	output logic                                dcache_ret_last,
	output logic [axi_bridge_pkg::data_w-1:0]   dcache_ret_data,
	// ar channel
	output logic [axi_bridge_pkg::id_w-1:0]     arid,
	output logic [axi_bridge_pkg::addr_w-1:0]   araddr,
	output logic [7:0]                          arlen,
	output logic                                arvalid,
	input  logic                                arready,
	// r channel
	input  logic [axi_bridge_pkg::id_w-1:0]     rid,
	input  logic [axi_bridge_pkg::data_w-1:0]   rdata,
	input  logic                                rlast,
	input  logic                                rvalid,
	output logic                                rready,
	// from the write engine
	input  logic                                wr_pending,
	input  logic [axi_bridge_pkg::addr_w-1:0]   wr_pending_addr
);

	localparam int hi = axi_bridge_pkg::addr_w - 1;
	localparam int lo = axi_bridge_pkg::line_off_w;

	axi_bridge_pkg::rd_state_e state;

	logic                              pick_dcache;
	logic                              any_req;
	logic [2:0]                        pick_type;
	logic [axi_bridge_pkg::addr_w-1:0] pick_addr;
	logic                              hazard;
	logic                              take;
	logic                              ar_hs;
	logic                              r_hs;
	logic                              beat_valid;
	logic                              beat_last;
	logic [axi_bridge_pkg::id_w-1:0]   beat_id;
	logic [axi_bridge_pkg::data_w-1:0] beat_data;

	assign pick_dcache = dcache_rd_req; // dcache wins a tie
	assign any_req     = dcache_rd_req | icache_rd_req;
	assign pick_type   = pick_dcache ? dcache_rd_type : icache_rd_type;
	assign pick_addr   = pick_dcache ? dcache_rd_addr : icache_rd_addr;

	// compared per line, so a word read inside an unfinished line write is held too
	assign hazard = wr_pending && (pick_addr[hi:lo] == wr_pending_addr[hi:lo]);
	assign take   = (state == axi_bridge_pkg::rd_idle) && any_req && !hazard;

	assign arvalid = (state == axi_bridge_pkg::rd_addr);
	assign rready  = (state == axi_bridge_pkg::rd_data);
	assign ar_hs   = arvalid & arready;
	assign r_hs    = rvalid & rready;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= axi_bridge_pkg::rd_idle;
		end else begin
			case (state)
				axi_bridge_pkg::rd_idle: if (take) state <= axi_bridge_pkg::rd_addr;
				axi_bridge_pkg::rd_addr: if (ar_hs) state <= axi_bridge_pkg::rd_data;
				axi_bridge_pkg::rd_data: if (r_hs && rlast) state <= axi_bridge_pkg::rd_done;
				default: state <= axi_bridge_pkg::rd_idle; // rd_done
			endcase
		end
	end

	// ar payload, held while arvalid waits
	always_ff @(posedge aclk) begin
		if (take) begin
			arid   <= pick_dcache ? axi_bridge_pkg::id_dcache : axi_bridge_pkg::id_icache;
			araddr <= pick_addr;
			arlen  <= (pick_type == axi_bridge_pkg::req_line) ? axi_bridge_pkg::line_len : 8'd0;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= r_hs; // return goes out one cycle after the beat
		end
	end

	always_ff @(posedge aclk) begin
		if (r_hs) begin
			beat_data <= rdata;
			beat_id   <= rid;
			beat_last <= rlast;
		end
	end

	assign icache_rd_rdy = ar_hs && (arid == axi_bridge_pkg::id_icache);
	assign dcache_rd_rdy = ar_hs && (arid == axi_bridge_pkg::id_dcache);

	// steer by the id that came back with the beat
	assign icache_ret_valid = beat_valid && (beat_id == axi_bridge_pkg::id_icache);
	assign dcache_ret_valid = beat_valid && (beat_id == axi_bridge_pkg::id_dcache);
	assign icache_ret_last  = icache_ret_valid && beat_last;
	assign dcache_ret_last  = dcache_ret_valid && beat_last;
	assign icache_ret_data  = beat_data;
	assign dcache_ret_data  = beat_data;

	ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// each return beat goes only to the cache whose read is in flight
	ret_one_owner: assert property (@(posedge aclk) disable iff (!aresetn)
		beat_valid |-> beat_id == arid);

endmodule

/* verilog/axi_write_engine.sv */
`timescale 1ns/1ps

module axi_write_engine (
	input  logic                                aclk,
	input  logic                                aresetn,
	// dcache write port
	input  logic                                dcache_wr_req,
	input  logic [2:0]                          dcache_wr_type,
	input  logic [axi_bridge_pkg::addr_w-1:0]   dcache_wr_addr,
	input  logic [3:0]                          dcache_wr_wstrb,
	input  logic [axi_bridge_pkg::line_words*axi_bridge_pkg::data_w-1:0] dcache_wr_data,
	output logic                                dcache_wr_rdy,
	// aw channel
	output logic [axi_bridge_pkg::id_w-1:0]     awid,
	output logic [axi_bridge_pkg::addr_w-1:0]   awaddr,
	output logic [7:0]                          awlen,
	output logic                                awvalid,
	input  logic                                awready,
	// w channel
	output logic [axi_bridge_pkg::data_w-1:0]   wdata,
	output logic [3:0]                          wstrb,
	output logic                                wlast,
	output logic                                wvalid,
	input  logic                                wready,
	// b channel
	input  logic                                bvalid,
	output logic                                bready,
	// to the read engine
	output logic                                wr_pending,
	output logic [axi_bridge_pkg::addr_w-1:0]   wr_pending_addr
);

	axi_bridge_pkg::wr_state_e state;

	logic [axi_bridge_pkg::line_words*axi_bridge_pkg::data_w-1:0] wr_buf;
	logic [7:0] beat_cnt;
	logic       accept;
	logic       aw_hs;
	logic       w_hs;
	logic       w_done;
	logic       b_hs;
	logic       b_done_q;

	assign dcache_wr_rdy = (state == axi_bridge_pkg::wr_idle);
	assign accept        = dcache_wr_req && dcache_wr_rdy;

	assign awid    = axi_bridge_pkg::id_dcache;
	assign awvalid = (state == axi_bridge_pkg::wr_both) || (state == axi_bridge_pkg::wr_addr_only);
	assign wvalid  = (state == axi_bridge_pkg::wr_both) || (state == axi_bridge_pkg::wr_data_only);
	assign bready  = (state == axi_bridge_pkg::wr_resp);
	assign wdata   = wr_buf[axi_bridge_pkg::data_w-1:0]; // low word leaves first
	assign wlast   = wvalid && (beat_cnt == awlen);

	assign aw_hs  = awvalid & awready;
	assign w_hs   = wvalid & wready;
	assign w_done = w_hs & wlast;
	assign b_hs   = bvalid & bready;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= axi_bridge_pkg::wr_idle;
		end else begin
			case (state)
				axi_bridge_pkg::wr_idle: begin
					if (accept) state <= axi_bridge_pkg::wr_both;
				end
				axi_bridge_pkg::wr_both: begin
					if (aw_hs && w_done)
						state <= axi_bridge_pkg::wr_resp;
					else if (aw_hs)
						state <= axi_bridge_pkg::wr_data_only;
					else if (w_done)
						state <= axi_bridge_pkg::wr_addr_only;
				end
				axi_bridge_pkg::wr_addr_only: if (aw_hs) state <= axi_bridge_pkg::wr_resp;
				axi_bridge_pkg::wr_data_only: if (w_done) state <= axi_bridge_pkg::wr_resp;
				default: if (b_hs) state <= axi_bridge_pkg::wr_idle; // wr_resp
			endcase
		end
	end

	// request capture and data shifter
	always_ff @(posedge aclk) begin
		if (accept) begin
			awaddr <= dcache_wr_addr;
			awlen  <= (dcache_wr_type == axi_bridge_pkg::req_line) ? axi_bridge_pkg::line_len
				: 8'd0;
			wstrb  <= dcache_wr_wstrb; // same strobes on every beat
			wr_buf <= dcache_wr_data;
		end else if (w_hs) begin
			wr_buf <= wr_buf >> axi_bridge_pkg::data_w;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			beat_cnt <= 8'd0;
		end else if (accept) begin
			beat_cnt <= 8'd0;
		end else if (w_hs) begin
			beat_cnt <= beat_cnt + 8'd1;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			b_done_q <= 1'b0;
		end else begin
			b_done_q <= b_hs;
		end
	end

	// covers the accept cycle too, before awaddr is loaded
	assign wr_pending      = accept || (state != axi_bridge_pkg::wr_idle) || b_done_q;
	assign wr_pending_addr = accept ? dcache_wr_addr : awaddr;

	// no further w beat once the last one is taken
	wlast_ends_w: assert property (@(posedge aclk) disable iff (!aresetn)
		w_done |=> !wvalid);

	aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

/* verilog/cache_axi_bridge.sv */
`timescale 1ns/1ps

module cache_axi_bridge (
	input  logic                                aclk,
	input  logic                                aresetn,
	// icache read port
	input  logic                                icache_rd_req,
	input  logic [2:0]                          icache_rd_type,
	input  logic [axi_bridge_pkg::addr_w-1:0]   icache_rd_addr,
	output logic                                icache_rd_rdy,
	output logic                                icache_ret_valid,
	output logic                                icache_ret_last,
	output logic [axi_bridge_pkg::data_w-1:0]   icache_ret_data,
	// dcache read port
	input  logic                                dcache_rd_req,
	input  logic [2:0]                          dcache_rd_type,
	input  logic [axi_bridge_pkg::addr_w-1:0]   dcache_rd_addr,
	output logic                                dcache_rd_rdy,
	output logic                                dcache_ret_valid,
	output logic                                dcache_ret_last,
	output logic [axi_bridge_pkg::data_w-1:0]   dcache_ret_data,
	// dcache write port
	input  logic                                dcache_wr_req,
	input  logic [2:0]                          dcache_wr_type,
	input  logic [axi_bridge_pkg::addr_w-1:0]   dcache_wr_addr,
	input  logic [3:0]                          dcache_wr_wstrb,
	input  logic [axi_bridge_pkg::line_words*axi_bridge_pkg::data_w-1:0] dcache_wr_data,
	output logic                                dcache_wr_rdy,
	// axi read side
	output logic [axi_bridge_pkg::id_w-1:0]     arid,
	output logic [axi_bridge_pkg::addr_w-1:0]   araddr,
	output logic [7:0]                          arlen,
	output logic                                arvalid,
	input  logic                                arready,
	input  logic [axi_bridge_pkg::id_w-1:0]     rid,
	input  logic [axi_bridge_pkg::data_w-1:0]   rdata,
	input  logic                                rlast,
	input  logic                                rvalid,
	output logic                                rready,
	// axi write side
	output logic [axi_bridge_pkg::id_w-1:0]     awid,
	output logic [axi_bridge_pkg::addr_w-1:0]   awaddr,
	output logic [7:0]                          awlen,
	output logic                                awvalid,
	input  logic                                awready,
	output logic [axi_bridge_pkg::data_w-1:0]   wdata,
	output logic [3:0]                          wstrb,
	output logic                                wlast,
	output logic                                wvalid,
	input  logic                                wready,
	input  logic                                bvalid,
	output logic                                bready
);

	// read-after-write hold, write engine to read engine
	logic                              wr_pending;
	logic [axi_bridge_pkg::addr_w-1:0] wr_pending_addr;

	axi_read_engine u_read (
		.aclk             (aclk),
		.aresetn          (aresetn),
		.icache_rd_req    (icache_rd_req),
		.icache_rd_type   (icache_rd_type),
		.icache_rd_addr   (icache_rd_addr),
		.icache_rd_rdy    (icache_rd_rdy),
		.icache_ret_valid (icache_ret_valid),
		.icache_ret_last  (icache_ret_last),
		.icache_ret_data  (icache_ret_data),
		.dcache_rd_req    (dcache_rd_req),
		.dcache_rd_type   (dcache_rd_type),
		.dcache_rd_addr   (dcache_rd_addr),
		.dcache_rd_rdy    (dcache_rd_rdy),
		.dcache_ret_valid (dcache_ret_valid),
		.dcache_ret_last  (dcache_ret_last),
		.dcache_ret_data  (dcache_ret_data),
		.arid             (arid),
		.araddr           (araddr),
		.arlen            (arlen),
		.arvalid          (arvalid),
		.arready          (arready),
		.rid              (rid),
		.rdata            (rdata),
		.rlast            (rlast),
		.rvalid           (rvalid),
		.rready           (rready),
		.wr_pending       (wr_pending),
		.wr_pending_addr  (wr_pending_addr)
	);

	axi_write_engine u_write (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.dcache_wr_req   (dcache_wr_req),
		.dcache_wr_type  (dcache_wr_type),
		.dcache_wr_addr  (dcache_wr_addr),
		.dcache_wr_wstrb (dcache_wr_wstrb),
		.dcache_wr_data  (dcache_wr_data),
		.dcache_wr_rdy   (dcache_wr_rdy),
		.awid            (awid),
		.awaddr          (awaddr),
		.awlen           (awlen),
		.awvalid         (awvalid),
		.awready         (awready),
		.wdata           (wdata),
		.wstrb           (wstrb),
		.wlast           (wlast),
		.wvalid          (wvalid),
		.wready          (wready),
		.bvalid          (bvalid),
		.bready          (bready),
		.wr_pending      (wr_pending),
		.wr_pending_addr (wr_pending_addr)
	);

endmodule

/* sim/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic [3:0]  arid,
	input  logic [31:0] araddr,
	input  logic [7:0]  arlen,
	input  logic        arvalid,
	output logic        arready,
	output logic [3:0]  rid,
	output logic [31:0] rdata,
	output logic        rlast,
	output logic        rvalid,
	input  logic        rready,
	input  logic [3:0]  awid,
	input  logic [31:0] awaddr,
	input  logic [7:0]  awlen,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wlast,
	input  logic        wvalid,
	output logic        wready,
	output logic        bvalid,
	input  logic        bready
);

	logic [31:0] mem [0:63]; // 256 byte window
	int          rseed;
	int          wseed;
	logic [1:0]  ar_dly, r_dly, aw_dly, w_dly, b_dly;
	logic        rd_busy;
	logic [31:0] rd_addr;
	logic [7:0]  rd_left;
	logic [3:0]  rd_id;
	logic        aw_got, w_got;
	logic [31:0] wr_addr;
	logic [31:0] wbuf [0:3];
	logic [3:0]  wsb [0:3];
	logic [2:0]  wcnt;

	initial begin
		rseed = 32'h30dc ^ 32'h0f0f;
		wseed = 32'h30dc ^ 32'hf0f0;
		for (int i = 0; i < 64; i++)
			mem[i] = (32'(i * 4) * 32'h9e3779b1) ^ 32'h5a5aa5a5; // same fill as the reference
	end

	// read side, one burst at a time
	always @(posedge aclk) begin
		if (!aresetn) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
			rd_busy <= 1'b0;
			ar_dly  <= 2'd0;
			r_dly   <= 2'd0;
		end else if (!rd_busy) begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				rd_busy <= 1'b1;
				rd_addr <= araddr;
				rd_left <= arlen;
				rd_id   <= arid;
				r_dly   <= 2'($random(rseed));
			end else if (arvalid && ar_dly == 2'd0) begin
				arready <= 1'b1;
			end else if (arvalid) begin
				ar_dly <= ar_dly - 2'd1;
			end else begin
				ar_dly <= 2'($random(rseed));
			end
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
			if (rlast) begin
				rd_busy <= 1'b0;
				ar_dly  <= 2'($random(rseed));
			end else begin
				rd_addr <= rd_addr + 32'd4;
				rd_left <= rd_left - 8'd1;
				r_dly   <= 2'($random(rseed));
			end
		end else if (!rvalid) begin
			if (r_dly == 2'd0) begin
				rvalid <= 1'b1;
				rdata  <= mem[rd_addr[7:2]]; // memory as it is at this beat
				rlast  <= (rd_left == 8'd0);
				rid    <= rd_id;
			end else begin
				r_dly <= r_dly - 2'd1;
			end
		end
	end

	// write side, aw and w accepted in either order
	always @(posedge aclk) begin
		if (!aresetn) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			wcnt    <= 3'd0;
			aw_dly  <= 2'd0;
			w_dly   <= 2'd0;
			b_dly   <= 2'd0;
		end else begin
			if (awvalid && awready) begin
				awready <= 1'b0;
				aw_got  <= 1'b1;
				wr_addr <= awaddr;
			end else if (awvalid && !aw_got) begin
				if (aw_dly == 2'd0)
					awready <= 1'b1;
				else
					aw_dly <= aw_dly - 2'd1;
			end
			if (wvalid && wready) begin
				wready          <= 1'b0;
				wbuf[wcnt[1:0]] <= wdata;
				wsb[wcnt[1:0]]  <= wstrb;
				wcnt            <= wcnt + 3'd1;
				w_got           <= wlast;
				w_dly           <= 2'($random(wseed));
			end else if (wvalid && !w_got) begin
				if (w_dly == 2'd0)
					wready <= 1'b1;
				else
					w_dly <= w_dly - 2'd1;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				wcnt   <= 3'd0;
				aw_dly <= 2'($random(wseed));
				b_dly  <= 2'($random(wseed));
			end else if (aw_got && w_got && !bvalid) begin
				if (b_dly == 2'd0) begin
					bvalid <= 1'b1;
					for (int k = 0; k < 4; k++)
						for (int b = 0; b < 4; b++)
							if (3'(k) < wcnt && wsb[k][b])
								mem[6'(wr_addr[7:2] + 6'(k))][8*b +: 8] <= wbuf[k][8*b +: 8];
				end else begin
					b_dly <= b_dly - 2'd1;
				end
			end
		end
	end

endmodule

/* sim/tb_cache_axi_bridge.sv */
`timescale 1ns/1ps

module tb_cache_axi_bridge;

	localparam int n_trans = 200;

	logic aclk, aresetn;
	logic icache_rd_req, dcache_rd_req, dcache_wr_req;
	logic [2:0] icache_rd_type, dcache_rd_type, dcache_wr_type;
	logic [31:0] icache_rd_addr, dcache_rd_addr, dcache_wr_addr;
	logic [3:0] dcache_wr_wstrb;
	logic [127:0] dcache_wr_data;
	logic icache_rd_rdy, icache_ret_valid, icache_ret_last;
	logic dcache_rd_rdy, dcache_ret_valid, dcache_ret_last, dcache_wr_rdy;
	logic [31:0] icache_ret_data, dcache_ret_data;
	logic [3:0] arid, rid, awid;
	logic [31:0] araddr, rdata, awaddr, wdata;
	logic [7:0] arlen, awlen;
	logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
	logic [3:0] wstrb;
	logic wlast, wvalid, wready, bvalid, bready;

	int seed = 32'h30dc;
	int errors = 0;
	int checks = 0;
	int beats = 0;
	int exp_beats = 0;
	int first_rdy;
	logic [7:0] exp_awlen = 8'd0; // burst length of the write in flight
	logic [31:0] ref_mem [0:63];
	logic [32:0] q_i [$]; // {last, data}
	logic [32:0] q_d [$];

	cache_axi_bridge i_dut (.*);
	axi_mem_model u_mem (.*);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic read_req(input bit is_d, input bit line, input logic [31:0] addr);
		logic [31:0] a;
		int n;
		a = line ? {addr[31:4], 4'b0} : {addr[31:2], 2'b0};
		n = line ? 4 : 1;
		if (is_d) begin
			dcache_rd_req  = 1'b1;
			dcache_rd_type = line ? axi_bridge_pkg::req_line : axi_bridge_pkg::req_word;
			dcache_rd_addr = a;
		end else begin
			icache_rd_req  = 1'b1;
			icache_rd_type = line ? axi_bridge_pkg::req_line : axi_bridge_pkg::req_word;
			icache_rd_addr = a;
		end
		do @(negedge aclk); while (!(is_d ? dcache_rd_rdy : icache_rd_rdy));
		if (first_rdy == 0)
			first_rdy = is_d ? 2 : 1;
		for (int k = 0; k < n; k++) begin
			if (is_d)
				q_d.push_back({k == n - 1, ref_mem[6'(a[7:2] + 6'(k))]});
			else
				q_i.push_back({k == n - 1, ref_mem[6'(a[7:2] + 6'(k))]});
		end
		exp_beats += n;
		if (is_d)
			dcache_rd_req = 1'b0; // handshake already taken, state left idle
		else
			icache_rd_req = 1'b0;
	endtask

	task automatic write_req(input bit line, input logic [31:0] addr, input logic [3:0] strb,
			input logic [127:0] data);
		logic [31:0] a;
		int n;
		while (q_i.size() != 0 || q_d.size() != 0)
			@(negedge aclk); // keep writes off lines still being returned
		a = line ? {addr[31:4], 4'b0} : {addr[31:2], 2'b0};
		n = line ? 4 : 1;
		dcache_wr_req   = 1'b1;
		dcache_wr_type  = line ? axi_bridge_pkg::req_line : axi_bridge_pkg::req_word;
		dcache_wr_addr  = a;
		dcache_wr_wstrb = strb;
		dcache_wr_data  = data;
		while (!dcache_wr_rdy)
			@(negedge aclk);
		exp_awlen = line ? 8'd3 : 8'd0;
		for (int k = 0; k < n; k++)
			for (int b = 0; b < 4; b++)
				if (strb[b])
					ref_mem[6'(a[7:2] + 6'(k))][8*b +: 8] = data[32*k + 8*b +: 8];
		@(negedge aclk);
		dcache_wr_req = 1'b0;
	endtask

	task automatic dual_read(input logic [31:0] ia, input logic [31:0] da, input bit il, input bit dl);
		first_rdy = 0;
		fork
			read_req(1'b0, il, ia);
			read_req(1'b1, dl, da);
		join
		check(32'(first_rdy), 32'd2, "first rd_rdy owner (2 is dcache)");
	endtask

	task automatic take_beat(input bit is_d, input logic [31:0] data, input logic last);
		logic [32:0] e;
		beats++;
		if (is_d ? q_d.size() == 0 : q_i.size() == 0) begin
			errors++;
			$display("Error at %0t: return beat on %s with nothing outstanding", $time,
				is_d ? "dcache" : "icache");
		end else begin
			e = is_d ? q_d.pop_front() : q_i.pop_front();
			check(data, e[31:0], is_d ? "dcache_ret_data" : "icache_ret_data");
			check(32'(last), 32'(e[32]), is_d ? "dcache_ret_last" : "icache_ret_last");
		end
	endtask

	// return monitor, sampled away from the active edge
	always @(negedge aclk) begin
		if (aresetn) begin
			if (icache_ret_valid && dcache_ret_valid) begin
				errors++;
				$display("Error at %0t: both caches got ret_valid in one cycle", $time);
			end
			if (icache_ret_valid)
				take_beat(1'b0, icache_ret_data, icache_ret_last);
			if (dcache_ret_valid)
				take_beat(1'b1, dcache_ret_data, dcache_ret_last);
			if (awvalid && awready) begin // aw handshake
				check(32'(awid), 32'd1, "awid");
				check(32'(awlen), 32'(exp_awlen), "awlen");
			end
		end
	end

	initial begin
		repeat ((n_trans + 10) * 200) @(posedge aclk);
		$display("Watchdog expired: the bridge hung with requests still outstanding");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] a;
		for (int i = 0; i < 64; i++)
			ref_mem[i] = (32'(i * 4) * 32'h9e3779b1) ^ 32'h5a5aa5a5;
		aresetn         = 1'b0;
		icache_rd_req   = 1'b0;
		icache_rd_type  = 3'd0;
		icache_rd_addr  = 32'd0;
		dcache_rd_req   = 1'b0;
		dcache_rd_type  = 3'd0;
		dcache_rd_addr  = 32'd0;
		dcache_wr_req   = 1'b0;
		dcache_wr_type  = 3'd0;
		dcache_wr_addr  = 32'd0;
		dcache_wr_wstrb = 4'd0;
		dcache_wr_data  = 128'd0;
		repeat (3) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;
		@(negedge aclk);

		// idle outputs right after reset
		check(32'({arvalid, awvalid, wvalid, rready, bready}), 32'd0, "bus strobes after reset");
		check(32'({icache_rd_rdy, dcache_rd_rdy, icache_ret_valid, dcache_ret_valid,
			icache_ret_last, dcache_ret_last}), 32'd0, "cache strobes after reset");
		check(32'(dcache_wr_rdy), 32'd1, "dcache_wr_rdy after reset");

		// directed warm up
		read_req(1'b0, 1'b0, 32'h24);
		read_req(1'b1, 1'b0, 32'h58);
		read_req(1'b0, 1'b1, 32'h40);
		read_req(1'b1, 1'b1, 32'h80);
		dual_read(32'h10, 32'h90, 1'b1, 1'b0);
		write_req(1'b0, 32'h64, 4'b0101, {96'd0, 32'hcafe1234});
		read_req(1'b1, 1'b0, 32'h64); // held behind the write
		write_req(1'b1, 32'hc0, 4'b1111, {32'h44444444, 32'h33333333, 32'h22222222, 32'h11111111});
		read_req(1'b0, 1'b1, 32'hc0);

		for (int t = 0; t < n_trans; t++) begin
			r = $random(seed);
			a = {24'd0, r[15:8]};
			case (r % 6)
				0: read_req(1'b0, r[4], a);
				1: read_req(1'b1, r[4], a);
				2: write_req(1'b0, a, r[3:0], {$random(seed), $random(seed), $random(seed),
					$random(seed)});
				3: write_req(1'b1, a, r[3:0], {$random(seed), $random(seed), $random(seed),
					$random(seed)});
				4: dual_read(a, {24'd0, r[23:16]}, r[4], r[5]);
				default: begin
					write_req(r[4], a, r[3:0], {$random(seed), $random(seed), $random(seed),
						$random(seed)});
					read_req(r[5], r[4], a);
				end
			endcase
		end

		// drain returns and the last write response
		while (q_i.size() != 0 || q_d.size() != 0 || !dcache_wr_rdy)
			@(negedge aclk);
		repeat (4) @(negedge aclk);
		check(32'(beats), 32'(exp_beats), "total ret_valid beats");

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* sim.f */
verilog/axi_bridge_pkg.sv
verilog/axi_read_engine.sv
verilog/axi_write_engine.sv
verilog/cache_axi_bridge.sv
sim/axi_mem_model.sv
sim/tb_cache_axi_bridge.sv

/* run_sim.sh */
#!/bin/bash
# Builds and runs the bridge testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f sim.f \
	--top-module tb_cache_axi_bridge \
	-o tb_cache_axi_bridge

./obj_dir/tb_cache_axi_bridge > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
	exit 0
else
	exit 1
fi
